// File: common/zs_compact_pkg.sv
package zs_compact_pkg;

	localparam int SLOTS_PER_ZSPAGE = 3;
	localparam int WAY_SHIFT        = 12;  // one zspage per 4 KiB way

	typedef logic [9:0]                  way_idx_t;
	typedef logic [31:0]                 axi_addr_t;
	typedef logic [31:0]                 axi_data_t;
	typedef logic [1:0]                  axi_resp_t;
	typedef logic [7:0]                  page_id_t;
	typedef logic [SLOTS_PER_ZSPAGE-1:0] slot_mask_t;
	typedef logic [1:0]                  slot_idx_t;
	typedef logic [1:0]                  size_cls_t;
	typedef axi_addr_t                   cpage_ptr_t;

	typedef enum logic [3:0] {
		IDLE, RD_SRC_AR, RD_SRC_R, RD_DST_AR, RD_DST_R,
		ISSUE, WAIT_MIG, FINISH, BUS_ERROR
	} ctrl_state_t;

	localparam cpage_ptr_t ZS_OFFSET = 32'd64;  // zspage header ahead of slot 0
	// byte size per class, entry 0 is the smallest
	localparam logic [3:0][15:0] CPAGE_SIZE_TBL = {16'd1280, 16'd1024, 16'd512, 16'd256};
	localparam logic [15:0] FREE_CPAGE_THRESHOLD = 16'd3;
	localparam axi_resp_t   RESP_OKAY            = 2'b00;

	// metadata word fields
	localparam int MD_VLD_LSB  = 0;  // valid mask, 2:0
	localparam int MD_SIZE_LSB = 4;  // size class, 5:4
	localparam int MD_PID_LSB  = 8;  // page ids of slots 0..2, one byte each

	// byte pointer of one slot inside a zspage
	function automatic cpage_ptr_t slot_ptr(way_idx_t way, slot_idx_t slot, size_cls_t cls);
		cpage_ptr_t base;
		cpage_ptr_t size;
		base = cpage_ptr_t'(way) << WAY_SHIFT;
		size = cpage_ptr_t'(CPAGE_SIZE_TBL[cls]);
		return base + ZS_OFFSET + cpage_ptr_t'(slot) * size;
	endfunction

endpackage

// File: common/zs_slot_if.sv
interface zs_slot_if;
	import zs_compact_pkg::*;

	logic       load;      // take md and way this cycle
	axi_data_t  md;
	way_idx_t   way;
	logic       advance;   // consume the slot picked now

	logic       has_slot;
	cpage_ptr_t slot_ptr;
	page_id_t   page_id;   // only meaningful on the source side

	modport ctrl (
		output load, md, way, advance,
		input  has_slot, slot_ptr, page_id
	);

	modport picker (
		input  load, md, way, advance,
		output has_slot, slot_ptr, page_id
	);

endinterface

// File: compacter/zs_slot_picker.sv
module zs_slot_picker #(
	parameter bit FIND_FREE = 1'b0  // 0 picks a valid slot, 1 picks an empty one
) (
	input logic       clk_i,
	input logic       rst_ni,
	zs_slot_if.picker slot
);
	import zs_compact_pkg::*;

	slot_mask_t mask_q;
	size_cls_t  cls_q;
	way_idx_t   way_q;
	page_id_t   pid_q [SLOTS_PER_ZSPAGE];

	slot_mask_t cand;
	slot_idx_t  pick;

	assign cand = FIND_FREE ? ~mask_q : mask_q;

	// lowest matching slot wins
	always_comb begin
		pick = '0;
		for (int i = SLOTS_PER_ZSPAGE - 1; i >= 0; i--) begin
			if (cand[i]) begin
				pick = slot_idx_t'(i);
			end
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			mask_q <= '0;
		end else if (slot.load) begin
			mask_q <= slot.md[MD_VLD_LSB +: SLOTS_PER_ZSPAGE];
		end else if (slot.advance) begin
			mask_q <= mask_q ^ (slot_mask_t'(1) << pick);  // source clears, dest sets
		end
	end

	// rest of the metadata word
	always_ff @(posedge clk_i) begin
		if (slot.load) begin
			cls_q <= slot.md[MD_SIZE_LSB +: $bits(size_cls_t)];
			way_q <= slot.way;
			for (int i = 0; i < SLOTS_PER_ZSPAGE; i++) begin
				pid_q[i] <= slot.md[MD_PID_LSB + i * $bits(page_id_t) +: $bits(page_id_t)];
			end
		end
	end

	assign slot.has_slot = |cand;
	assign slot.slot_ptr = slot_ptr(way_q, pick, cls_q);
	assign slot.page_id  = pid_q[pick];

	// the controller only consumes a slot it has seen offered
	a_advance_has_slot: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		slot.advance |-> slot.has_slot
	);

endmodule

// File: compacter/zs_compact_ctrl.sv
module zs_compact_ctrl (
	input  logic                       clk_i,
	input  logic                       rst_ni,
	input  logic                       decomp_done,
	input  logic                       compact_trig,
	input  zs_compact_pkg::way_idx_t   ifl_head,
	input  zs_compact_pkg::way_idx_t   ifl_tail,

	output zs_compact_pkg::axi_addr_t  araddr,
	output logic                       arvalid,
	input  logic                       arready,
	input  zs_compact_pkg::axi_data_t  rdata,
	input  zs_compact_pkg::axi_resp_t  rresp,
	input  logic                       rvalid,
	output logic                       rready,

	output logic                       mig_valid,
	input  logic                       mig_ready,
	output zs_compact_pkg::cpage_ptr_t mig_src_ptr,
	output zs_compact_pkg::cpage_ptr_t mig_dst_ptr,
	output zs_compact_pkg::page_id_t   mig_page_id,

	output logic                       compact_req,
	output logic                       compact_done,
	output logic                       src_freed,
	output logic                       dst_full,
	output logic                       bus_error,

	zs_slot_if.ctrl                    src,
	zs_slot_if.ctrl                    dst
);
	import zs_compact_pkg::*;

	ctrl_state_t state_q;
	logic [15:0] free_cnt_q;  // decompressions since last compaction
	way_idx_t    src_way_q;
	way_idx_t    dst_way_q;

	logic start;
	logic beat_ok;
	logic beat_err;
	logic both_slots;
	logic issue_go;

	assign start      = compact_trig && (ifl_head != ifl_tail);  // need two zspages
	assign beat_ok    = rvalid && rready && (rresp == RESP_OKAY);
	assign beat_err   = rvalid && rready && (rresp != RESP_OKAY);
	assign both_slots = src.has_slot && dst.has_slot;
	assign issue_go   = (state_q == ISSUE) && both_slots;

	// read channel, tail first then head
	assign arvalid = (state_q == RD_SRC_AR) || (state_q == RD_DST_AR);
	assign rready  = (state_q == RD_SRC_R) || (state_q == RD_DST_R);
	assign araddr  = axi_addr_t'((state_q == RD_DST_AR) ? dst_way_q : src_way_q) << WAY_SHIFT;

	assign src.load    = beat_ok && (state_q == RD_SRC_R);
	assign dst.load    = beat_ok && (state_q == RD_DST_R);
	assign src.md      = rdata;
	assign dst.md      = rdata;
	assign src.way     = src_way_q;
	assign dst.way     = dst_way_q;
	assign src.advance = issue_go;
	assign dst.advance = issue_go;

	assign mig_valid = (state_q == WAIT_MIG);  // payload held in regs below

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= IDLE;
		end else begin
			case (state_q)
				IDLE: if (start) state_q <= RD_SRC_AR;
				RD_SRC_AR: if (arready) state_q <= RD_SRC_R;
				RD_SRC_R: begin
					if (beat_err) begin
						state_q <= BUS_ERROR;
					end else if (beat_ok) begin
						state_q <= RD_DST_AR;
					end
				end
				RD_DST_AR: if (arready) state_q <= RD_DST_R;
				RD_DST_R: begin
					if (beat_err) begin
						state_q <= BUS_ERROR;
					end else if (beat_ok) begin
						state_q <= ISSUE;
					end
				end
				ISSUE: state_q <= both_slots ? WAIT_MIG : FINISH;  // nothing to move at all
				WAIT_MIG: begin
					if (mig_ready) begin
						state_q <= both_slots ? ISSUE : FINISH;
					end
				end
				FINISH: state_q <= IDLE;
				BUS_ERROR: state_q <= BUS_ERROR;  // sticky until reset
				default: state_q <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if ((state_q == IDLE) && start) begin
			src_way_q <= ifl_tail;
			dst_way_q <= ifl_head;
		end
		if (issue_go) begin
			mig_src_ptr <= src.slot_ptr;
			mig_dst_ptr <= dst.slot_ptr;
			mig_page_id <= src.page_id;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			free_cnt_q <= '0;
		end else if (compact_done) begin
			free_cnt_q <= '0;
		end else if (decomp_done && (free_cnt_q != '1)) begin
			free_cnt_q <= free_cnt_q + 16'd1;  // saturates
		end
	end

	assign compact_done = (state_q == FINISH);
	assign compact_req  = (free_cnt_q >= FREE_CPAGE_THRESHOLD) && !compact_done;
	assign src_freed    = compact_done && !src.has_slot;
	assign dst_full     = compact_done && !dst.has_slot;
	assign bus_error    = (state_q == BUS_ERROR);

	a_ar_hold: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		arvalid && !arready |=> arvalid && $stable(araddr)
	);

	a_mig_hold: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		mig_valid && !mig_ready |=> mig_valid && $stable({mig_src_ptr, mig_dst_ptr, mig_page_id})
	);

	// one outstanding operation of either kind
	a_ar_mig_excl: assert property (
		@(posedge clk_i) disable iff (!rst_ni)
		!(arvalid && mig_valid)
	);

endmodule

// File: hw/zs_compacter_top.sv
module zs_compacter_top (
	input  logic                       clk_i,
	input  logic                       rst_ni,

	input  logic                       decomp_done,
	input  logic                       compact_trig,
	input  zs_compact_pkg::way_idx_t   ifl_head,
	input  zs_compact_pkg::way_idx_t   ifl_tail,

	// AXI4-Lite read master
	output zs_compact_pkg::axi_addr_t  araddr,
	output logic                       arvalid,
	input  logic                       arready,
	input  zs_compact_pkg::axi_data_t  rdata,
	input  zs_compact_pkg::axi_resp_t  rresp,
	input  logic                       rvalid,
	output logic                       rready,

	// migrate commands
	output logic                       mig_valid,
	input  logic                       mig_ready,
	output zs_compact_pkg::cpage_ptr_t mig_src_ptr,
	output zs_compact_pkg::cpage_ptr_t mig_dst_ptr,
	output zs_compact_pkg::page_id_t   mig_page_id,

	output logic                       compact_req,
	output logic                       compact_done,
	output logic                       src_freed,
	output logic                       dst_full,
	output logic                       bus_error
);

	zs_slot_if src_slot ();
	zs_slot_if dst_slot ();

	zs_compact_ctrl u_ctrl (
		.clk_i, .rst_ni, .decomp_done, .compact_trig, .ifl_head, .ifl_tail,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.mig_valid, .mig_ready, .mig_src_ptr, .mig_dst_ptr, .mig_page_id,
		.compact_req, .compact_done, .src_freed, .dst_full, .bus_error,
		.src (src_slot.ctrl),
		.dst (dst_slot.ctrl)
	);

	zs_slot_picker #(.FIND_FREE(1'b0)) u_src_pick (  // tail zspage, valid pages
		.clk_i,
		.rst_ni,
		.slot (src_slot.picker)
	);

	zs_slot_picker #(.FIND_FREE(1'b1)) u_dst_pick (  // head zspage, free slots
		.clk_i,
		.rst_ni,
		.slot (dst_slot.picker)
	);

endmodule

// File: tests/tb_zs_compacter.sv
module tb_zs_compacter;
	import zs_compact_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int RST_CYCLES  = 16;
	localparam int N_CMP       = 24;         // random compaction runs
	localparam int NUM_TESTS   = N_CMP + 3;
	localparam int TEST_CYCLES = 500;        // generous bound per test
	localparam int WAIT_LIMIT  = 400;
	localparam logic [31:0] SEED = 32'h6b6f_de1c;

	logic clk_i = 1'b0;
	logic rst_ni;
	logic decomp_done, compact_trig;
	way_idx_t ifl_head, ifl_tail;
	axi_addr_t araddr;
	logic arvalid, arready, rvalid, rready;
	axi_data_t rdata;
	axi_resp_t rresp;
	logic mig_valid, mig_ready;
	cpage_ptr_t mig_src_ptr, mig_dst_ptr;
	page_id_t mig_page_id;
	logic compact_req, compact_done, src_freed, dst_full, bus_error;

	logic [31:0] seed_main = SEED;
	logic [31:0] seed_bus = ~SEED;         // separate stream for the bus side
	logic [31:0] md_mem [1024];            // metadata word per way
	axi_addr_t   ar_q [$];
	logic [71:0] mig_q [$];                // {src ptr, dst ptr, page id}
	int          done_cnt = 0;
	logic        done_freed, done_full;
	logic        rd_pend = 1'b0;
	way_idx_t    rd_way;
	logic        err_mode = 1'b0;
	int          model_cnt = 0;
	int          errors = 0;
	int          tests_failed = 0;

	zs_compacter_top UUT (.*);

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function logic [31:0] rand_main();
		seed_main = lcg_next(seed_main);
		return seed_main ^ (seed_main >> 15);  // mix high bits down
	endfunction

	function logic [31:0] rand_bus();
		seed_bus = lcg_next(seed_bus);
		return seed_bus ^ (seed_bus >> 15);
	endfunction

	// way base + header + slot times class size
	function automatic logic [31:0] model_ptr(input way_idx_t way, input int slot,
			input logic [1:0] cls);
		logic [31:0] size;
		case (cls)
			2'd0: size = 32'd256;
			2'd1: size = 32'd512;
			2'd2: size = 32'd1024;
			default: size = 32'd1280;
		endcase
		return {12'b0, way, 10'b0} * 32'd4 + 32'd64 + slot * size;
	endfunction

	function automatic int lowest_set(input logic [2:0] m);
		int r;
		r = 0;
		for (int i = 2; i >= 0; i--) begin
			if (m[i]) r = i;
		end
		return r;
	endfunction

	task automatic expect_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cond(input bit cond, input string what);
		assert (cond) else begin
			$display("ERROR: %s", what);
			errors++;
		end
	endtask

	task automatic report_test(input int n, input string what, input int err_before);
		if (errors != err_before) tests_failed++;
		$display("test %0d %s: %s", n, what, (errors == err_before) ? "ok" : "errors");
	endtask

	task automatic pulse_decomp();
		decomp_done = 1'b1;
		@(negedge clk_i);
		decomp_done = 1'b0;
	endtask

	task automatic trigger(input way_idx_t head, input way_idx_t tail);
		ifl_head = head;
		ifl_tail = tail;
		compact_trig = 1'b1;
		@(negedge clk_i);
		compact_trig = 1'b0;
	endtask

	task automatic threshold_test(input int n);
		int e0;
		e0 = errors;
		for (int k = 0; k < int'(FREE_CPAGE_THRESHOLD); k++) begin
			expect_equal("compact_req", 32'(compact_req), 32'd0);
			pulse_decomp();
		end
		expect_equal("compact_req", 32'(compact_req), 32'd1);
		model_cnt = int'(FREE_CPAGE_THRESHOLD);
		report_test(n, "threshold", e0);
	endtask

	task automatic run_compaction(input int n);
		way_idx_t tail, head;
		logic [31:0] smd, dmd;
		logic [2:0] smask, dmask;
		logic [71:0] exp_q [$];
		int s, d, npulse, cyc, nexp, e0;
		e0 = errors;
		tail = way_idx_t'(rand_main());
		head = way_idx_t'(rand_main());
		if (head == tail) head = tail ^ 10'd1;
		smd = rand_main();  // mask, class and page ids all random
		dmd = rand_main();
		md_mem[tail] = smd;
		md_mem[head] = dmd;
		smask = smd[2:0];
		dmask = dmd[2:0];
		nexp = ($countones(smask) < 3 - $countones(dmask)) ?
			$countones(smask) : 3 - $countones(dmask);
		while (smask != 3'b000 && dmask != 3'b111) begin
			s = lowest_set(smask);
			d = lowest_set(~dmask);
			exp_q.push_back({model_ptr(tail, s, smd[5:4]), model_ptr(head, d, dmd[5:4]),
				smd[8 + 8 * s +: 8]});
			smask[s] = 1'b0;
			dmask[d] = 1'b1;
		end
		ar_q.delete();
		mig_q.delete();
		done_cnt = 0;
		npulse = int'(rand_main() % 5);
		repeat (npulse) pulse_decomp();
		model_cnt += npulse;
		expect_equal("compact_req", 32'(compact_req), 32'(model_cnt >= 3));
		trigger(head, tail);
		cyc = 0;
		while (done_cnt == 0 && cyc < WAIT_LIMIT) begin
			@(negedge clk_i);
			cyc++;
		end
		check_cond(done_cnt == 1, "compact_done did not pulse exactly once in time");
		expect_equal("read count", 32'(ar_q.size()), 32'd2);
		if (ar_q.size() == 2) begin
			expect_equal("araddr (src)", ar_q[0], {12'b0, tail, 10'b0} * 32'd4);
			expect_equal("araddr (dst)", ar_q[1], {12'b0, head, 10'b0} * 32'd4);
		end
		expect_equal("migrate count", 32'(mig_q.size()), 32'(nexp));
		for (int i = 0; i < mig_q.size() && i < exp_q.size(); i++) begin
			expect_equal("mig_src_ptr", mig_q[i][71:40], exp_q[i][71:40]);
			expect_equal("mig_dst_ptr", mig_q[i][39:8], exp_q[i][39:8]);
			expect_equal("mig_page_id", 32'(mig_q[i][7:0]), 32'(exp_q[i][7:0]));
		end
		expect_equal("src_freed", 32'(done_freed), 32'(smask == 3'b000));
		expect_equal("dst_full", 32'(done_full), 32'(dmask == 3'b111));
		model_cnt = 0;  // counter clears on compact_done
		expect_equal("compact_req", 32'(compact_req), 32'd0);
		report_test(n, $sformatf("compaction tail %h head %h, %0d commands", tail, head, nexp),
			e0);
	endtask

	task automatic single_entry_test(input int n);
		way_idx_t way;
		int e0;
		e0 = errors;
		way = way_idx_t'(rand_main());
		ar_q.delete();
		done_cnt = 0;
		trigger(way, way);
		repeat (30) @(negedge clk_i);
		expect_equal("read count", 32'(ar_q.size()), 32'd0);
		expect_equal("compact_done count", 32'(done_cnt), 32'd0);
		report_test(n, "single entry list", e0);
	endtask

	task automatic bus_error_test(input int n);
		way_idx_t tail;
		int cyc, e0;
		e0 = errors;
		tail = way_idx_t'(rand_main());
		err_mode = 1'b1;
		ar_q.delete();
		mig_q.delete();
		done_cnt = 0;
		trigger(tail ^ 10'h155, tail);
		cyc = 0;
		while (!bus_error && cyc < WAIT_LIMIT) begin
			@(negedge clk_i);
			cyc++;
		end
		check_cond(bus_error, "bus_error not raised after an error response");
		repeat (10) @(negedge clk_i);
		trigger(tail ^ 10'h0aa, tail);  // must be ignored
		repeat (30) @(negedge clk_i);
		expect_equal("bus_error", 32'(bus_error), 32'd1);
		expect_equal("read count", 32'(ar_q.size()), 32'd1);
		expect_equal("migrate count", 32'(mig_q.size()), 32'd0);
		expect_equal("compact_done count", 32'(done_cnt), 32'd0);
		report_test(n, "bus error", e0);
	endtask

	// bus monitor sees the values from before the edge
	always @(posedge clk_i) begin
		if (rst_ni) begin
			if (rvalid && rready) rd_pend = 1'b0;
			if (arvalid && arready) begin
				ar_q.push_back(araddr);
				rd_way = araddr[21:12];
				rd_pend = 1'b1;
			end
			if (mig_valid && mig_ready) mig_q.push_back({mig_src_ptr, mig_dst_ptr, mig_page_id});
			if (compact_done) begin
				done_cnt++;
				done_freed = src_freed;
				done_full = dst_full;
			end
		end
	end

	// read responder and random back-pressure
	always @(negedge clk_i) begin
		logic [31:0] r;
		if (rst_ni) begin
			r = rand_bus();
			arready = r[0] | r[1];
			mig_ready = r[2] | r[3];
			if (!rd_pend) begin
				rvalid = 1'b0;
				rresp = RESP_OKAY;
			end else if (!rvalid && r[4]) begin  // random response delay
				rvalid = 1'b1;
				rdata = md_mem[rd_way];
				rresp = err_mode ? 2'b10 : RESP_OKAY;
			end
		end
	end

	initial begin
		for (int i = 0; i < 1024; i++) md_mem[i] = 32'(i) * 32'h9e37_79b9;
		rst_ni = 1'b0;
		decomp_done = 1'b0;
		compact_trig = 1'b0;
		ifl_head = '0;
		ifl_tail = '0;
		arready = 1'b0;
		rdata = '0;
		rresp = RESP_OKAY;
		rvalid = 1'b0;
		mig_ready = 1'b0;
		repeat (RST_CYCLES) @(negedge clk_i);
		rst_ni = 1'b1;
		@(negedge clk_i);
		threshold_test(1);
		for (int i = 0; i < N_CMP; i++) run_compaction(i + 2);
		single_entry_test(N_CMP + 2);
		bus_error_test(N_CMP + 3);
		$display("%0d tests, %0d failed, %0d check errors", NUM_TESTS, tests_failed, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	initial begin
		#((RST_CYCLES + NUM_TESTS * TEST_CYCLES) * CLK_PERIOD);
		$display("watchdog expired, the tests did not finish in time");
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: files.f
common/zs_compact_pkg.sv
common/zs_slot_if.sv
compacter/zs_slot_picker.sv
compacter/zs_compact_ctrl.sv
hw/zs_compacter_top.sv
tests/tb_zs_compacter.sv
